/* Bender.yml */
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/register_file.sv
  - hdl/fetch_unit.sv
  - hdl/decode_stage.sv
  - hdl/execute_alu.sv
  - hdl/rv_core_top.sv
  - target: simulation
    files:
      - dv/clock_gen.sv
      - dv/tb_rv_core.sv

/* dv/clock_gen.sv */
/* Free-running testbench clock and a synchronous reset held for a fixed cycle count.
   Reset is released with a non-blocking assignment on a rising edge. */
`timescale 1ns/1ps

module clock_gen #(
  parameter int half_period  = 2,   // 4 ns period
  parameter int reset_cycles = 16
) (
  output logic clk_div,
  output logic reset
);

  initial begin
    clk_div = 1'b0;
    forever #(half_period) clk_div = ~clk_div;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk_div);
    reset <= 1'b0;
  end

endmodule

/* dv/tb_rv_core.sv */
/* Random OP, OP-IMM and LUI program on x0..x7 over a Wishbone slave with 0 to 3 wait states.
   Retires are checked in order against a model register file; NOPs follow the program. */
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int          prog_len     = 200;
  localparam int          clk_period   = 4;
  localparam int          reset_cycles = 16;
  localparam int          timeout_ns   = prog_len * 8 * clk_period + reset_cycles * clk_period;
  localparam logic [31:0] nop_word     = 32'h0000_0013;  // ADDI x0, x0, 0

  logic     clk_div;
  logic     reset;
  logic     wb_cyc;
  logic     wb_stb;
  xword_t   wb_adr;
  logic     wb_ack;
  instr_t   wb_dat_i;
  logic     retire_valid;
  reg_idx_t retire_rd;
  xword_t   retire_data;

  integer   seed;
  instr_t   prog [prog_len];
  xword_t   model_regs [32];
  int       wait_cnt;
  logic     in_txn;       // Slave has seen the current stb
  xword_t   exp_adr;
  int       retired_count;
  int       mismatch_errs;
  int       other_errs;
  instr_t   ret_ins;
  reg_idx_t exp_rd;
  xword_t   exp_val;

  clock_gen #(.half_period(clk_period / 2), .reset_cycles(reset_cycles)) u_clk (
    .clk_div, .reset
  );

  rv_core_top #(.pc_reset(64'd0), .sp_reset(64'd128)) DUT (
    .clk_div, .reset,
    .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_i,
    .retire_valid, .retire_rd, .retire_data
  );

  function automatic instr_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic instr_t program_word(input longint unsigned idx);
    if (idx < prog_len) begin
      return prog[idx];
    end
    return nop_word;
  endfunction

  // Expected write-back of one instruction on the model registers
  function automatic xword_t expected_result(input instr_t ins, output reg_idx_t rd);
    xword_t     a;
    xword_t     b;
    xword_t     imm;
    xword_t     res;
    logic [5:0] sh;
    rd  = ins[11:7];
    a   = model_regs[ins[19:15]];
    b   = model_regs[ins[24:20]];
    imm = {{52{ins[31]}}, ins[31:20]};
    res = '0;
    if (ins[6:0] == 7'b0110111) begin
      res = {{32{ins[31]}}, ins[31:12], 12'h000};
    end else begin
      if (ins[6:0] == 7'b0010011) begin
        b  = imm;
        sh = ins[25:20];  // RV64 immediate shamt
      end else begin
        sh = b[5:0];
      end
      case (ins[14:12])
        3'b000: res = (ins[6:0] == 7'b0110011 && ins[30]) ? a - b : a + b;
        3'b001: res = a << sh;
        3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'b011: res = (a < b) ? 64'd1 : 64'd0;
        3'b100: res = a ^ b;
        3'b101: begin
          res = a >> sh;
          if (ins[30] && a[63]) begin
            res = res | ~({64{1'b1}} >> sh);  // Sign fill for SRA
          end
        end
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end
    return res;
  endfunction

  task automatic build_program();
    int          kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [5:0]  sh;
    logic [11:0] imm;
    logic [31:0] rnd;
    for (int i = 0; i < prog_len; i++) begin
      kind = $random(seed) & 15;  // 0..6 R, 7..13 I, 14..15 LUI
      f3   = $random(seed);
      rd   = $random(seed) & 7;
      rs1  = $random(seed) & 7;
      rs2  = $random(seed) & 7;
      sh   = $random(seed);
      rnd  = $random(seed);
      if (kind < 7) begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && rnd[0]) ? 7'b0100000 : 7'b0000000;
        prog[i] = r_type_word(f7, rs2, rs1, f3, rd);
      end else if (kind < 14) begin
        if (f3 == 3'b001) begin
          imm = {6'b000000, sh};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, rnd[0], 4'b0000, sh};  // SRAI when bit 30 set
        end else begin
          imm = rnd[11:0];
        end
        prog[i] = i_type_word(imm, rs1, f3, rd);
      end else begin
        prog[i] = {rnd[19:0], rd, 7'b0110111};
      end
    end
  endtask

  // Wishbone slave that draws a wait count when a new stb is first seen
  always @(posedge clk_div) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      in_txn   <= 1'b0;
      wait_cnt <= 0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
      in_txn <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_txn) begin
        in_txn   <= 1'b1;
        wait_cnt <= $random(seed) & 3;
      end else if (wait_cnt == 0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= program_word(wb_adr >> 2);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  always @(posedge clk_div) begin
    if (reset) begin
      exp_adr <= '0;
    end else if (wb_cyc && wb_stb && wb_ack) begin
      assert (wb_adr == exp_adr) else begin
        $display("mismatch wb_adr: got %h expected %h", wb_adr, exp_adr);
        mismatch_errs++;
      end
      exp_adr <= exp_adr + 64'd4;
    end
  end

  // In-order retire compare
  always @(posedge clk_div) begin
    if (!reset && retire_valid) begin
      ret_ins = program_word(retired_count);
      exp_val = expected_result(ret_ins, exp_rd);
      assert (retire_rd == exp_rd) else begin
        $display("mismatch retire_rd: got %h expected %h (retire %0d, instr %h)",
                 retire_rd, exp_rd, retired_count, ret_ins);
        mismatch_errs++;
      end
      assert (retire_data == exp_val) else begin
        $display("mismatch retire_data: got %h expected %h (retire %0d, instr %h)",
                 retire_data, exp_val, retired_count, ret_ins);
        mismatch_errs++;
      end
      if (exp_rd != '0) begin
        model_regs[exp_rd] = exp_val;
      end
      retired_count++;
    end
  end

  initial begin
    wb_ack        = 1'b0;
    wb_dat_i      = '0;
    seed          = 32'hc530_5cc3;
    retired_count = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = (r == 2) ? 64'd128 : 64'd0;
    end
    build_program();
    while (retired_count < prog_len) @(posedge clk_div);
    repeat (4) @(posedge clk_div);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    other_errs++;
    $display("Pipeline stopped retiring, only %0d of %0d instructions retired",
             retired_count, prog_len);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    $display("Checks failed");
    $finish;
  end

endmodule

/* hdl/decode_stage.sv */
/* Decode and execute register with a stall-only RAW interlock, no forwarding.
   Instructions outside OP, OP-IMM and LUI are not supported. */
`timescale 1ns/1ps

module decode_stage (
  input  logic             clk_div,
  input  logic             reset,
  input  logic             instr_valid,
  input  rv_pkg::instr_t   instr,
  output logic             instr_take,
  output rv_pkg::reg_idx_t rs1_addr,
  output rv_pkg::reg_idx_t rs2_addr,
  input  rv_pkg::xword_t   rs1_data,
  input  rv_pkg::xword_t   rs2_data,
  input  logic             wb_valid,
  input  rv_pkg::reg_idx_t wb_rd,
  output logic             ex_valid,
  output rv_pkg::alu_op_t  ex_op,
  output rv_pkg::xword_t   ex_a,
  output rv_pkg::xword_t   ex_b,
  output rv_pkg::reg_idx_t ex_rd
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  xword_t     imm_i;
  xword_t     imm_u;
  xword_t     shamt;
  xword_t     op_b;
  alu_op_t    op;
  logic       alt;
  logic       use_rs1;
  logic       use_rs2;
  logic       hit_ex;
  logic       hit_wb;

  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign funct7   = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};  // LUI, sign extended
  assign shamt = {{(xlen-shamt_w){1'b0}}, instr[20 +: shamt_w]};

  // Bit 25 is shamt[5] for RV64 immediate shifts
  assign alt = (opcode == op_reg) ? (funct7 == f7_alt) : (funct7[6:1] == f7_alt[6:1]);

  always_comb begin
    case (funct3)
      f3_add:  op = (opcode == op_reg && alt) ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      f3_and:  op = alu_and;
      default: op = alu_add;
    endcase
    if (opcode == op_lui) begin
      op = alu_pass_b;
    end
  end

  always_comb begin
    if (opcode == op_lui) begin
      op_b = imm_u;
    end else if (opcode == op_reg) begin
      op_b = rs2_data;
    end else if (funct3 == f3_sll || funct3 == f3_sr) begin
      op_b = shamt;
    end else begin
      op_b = imm_i;
    end
  end

  // RAW check against both later stages, rs2 only for R-type
  assign use_rs1 = (opcode == op_reg) || (opcode == op_imm);
  assign use_rs2 = (opcode == op_reg);
  assign hit_ex  = ex_valid && ex_rd != '0 &&
                   ((use_rs1 && rs1_addr == ex_rd) || (use_rs2 && rs2_addr == ex_rd));
  assign hit_wb  = wb_valid && wb_rd != '0 &&
                   ((use_rs1 && rs1_addr == wb_rd) || (use_rs2 && rs2_addr == wb_rd));

  assign instr_take = instr_valid && !hit_ex && !hit_wb;

  always_ff @(posedge clk_div) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= instr_take;  // Bubble while stalled
    end
  end

  always_ff @(posedge clk_div) begin
    if (instr_take) begin
      ex_op <= op;
      ex_a  <= rs1_data;
      ex_b  <= op_b;
      ex_rd <= rd;
    end
  end

  assert property (@(posedge clk_div) disable iff (reset)
    instr_take |-> (opcode == op_imm) || (opcode == op_lui) ||
                   (opcode == op_reg && (funct7 == f7_base || funct7 == f7_alt)))
    else $error("Unsupported instruction %h consumed", instr);

endmodule

/* hdl/execute_alu.sv */
/* 64-bit integer ALU and write-back register. The write-back register feeds
   the retire port, the register file write and the decode interlock. */
`timescale 1ns/1ps

module execute_alu (
  input  logic             clk_div,
  input  logic             reset,
  input  logic             ex_valid,
  input  rv_pkg::alu_op_t  ex_op,
  input  rv_pkg::xword_t   ex_a,
  input  rv_pkg::xword_t   ex_b,
  input  rv_pkg::reg_idx_t ex_rd,
  output logic             retire_valid,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::xword_t   retire_data
);
  import rv_pkg::*;

  logic [shamt_w-1:0] shamt;
  xword_t             result;

  assign shamt = ex_b[shamt_w-1:0];  // Low 6 bits only

  always_comb begin
    case (ex_op)
      alu_add:    result = ex_a + ex_b;
      alu_sub:    result = ex_a - ex_b;
      alu_sll:    result = ex_a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, ex_a < ex_b};
      alu_xor:    result = ex_a ^ ex_b;
      alu_srl:    result = ex_a >> shamt;
      alu_sra:    result = xword_t'($signed(ex_a) >>> shamt);  // Sign fill
      alu_or:     result = ex_a | ex_b;
      alu_and:    result = ex_a & ex_b;
      alu_pass_b: result = ex_b;
      default:    result = '0;
    endcase
  end

  // One retire pulse per instruction, x0 writes included
  always_ff @(posedge clk_div) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk_div) begin
    if (ex_valid) begin
      retire_rd   <= ex_rd;
      retire_data <= result;
    end
  end

  assert property (@(posedge clk_div) disable iff (reset)
    !$isunknown(retire_valid))
    else $error("retire_valid unknown after reset");

endmodule

/* hdl/fetch_unit.sv */
/* Wishbone classic fetch master, one cycle in flight, no error or retry handling.
   The slave returns the word at wb_adr; wb_we is implied low. */
`timescale 1ns/1ps

module fetch_unit #(
  parameter rv_pkg::xword_t pc_reset = 64'd0
) (
  input  logic           clk_div,
  input  logic           reset,
  output logic           wb_cyc,
  output logic           wb_stb,
  output rv_pkg::xword_t wb_adr,
  input  logic           wb_ack,
  input  rv_pkg::instr_t wb_dat_i,
  input  logic           instr_take,
  output logic           instr_valid,
  output rv_pkg::instr_t instr
);
  import rv_pkg::*;

  xword_t pc;
  logic   busy;      // Bus cycle open
  logic   buf_room;  // Buffer empty after this edge

  assign buf_room = !instr_valid || instr_take;
  assign wb_cyc   = busy;
  assign wb_stb   = busy;  // Single transfer per cycle
  assign wb_adr   = pc;

  always_ff @(posedge clk_div) begin
    if (reset) begin
      busy <= 1'b0;
      pc   <= pc_reset;
    end else if (busy) begin
      if (wb_ack) begin
        busy <= 1'b0;       // Drop stb the cycle after ack
        pc   <= pc + 64'd4;
      end
    end else if (buf_room) begin
      busy <= 1'b1;
    end
  end

  // A cycle only opens once the buffer is empty, so an ack always has a slot
  always_ff @(posedge clk_div) begin
    if (reset) begin
      instr_valid <= 1'b0;
    end else if (busy && wb_ack) begin
      instr_valid <= 1'b1;
    end else if (instr_take) begin
      instr_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_div) begin
    if (busy && wb_ack) begin
      instr <= wb_dat_i;  // Data valid in the ack cycle
    end
  end

  assert property (@(posedge clk_div) disable iff (reset)
    wb_stb && !wb_ack |=> $stable(wb_adr))
    else $error("wb_adr changed during a wait state");

endmodule

/* hdl/register_file.sv */
/* 32 x 64-bit registers, two combinational reads, one write.
   A write is seen by a read only from the next cycle on. */
`timescale 1ns/1ps

module register_file #(
  parameter rv_pkg::xword_t sp_reset = 64'd128
) (
  input  logic             clk_div,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_addr,
  input  rv_pkg::reg_idx_t rs2_addr,
  output rv_pkg::xword_t   rs1_data,
  output rv_pkg::xword_t   rs2_data,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_addr,
  input  rv_pkg::xword_t   wr_data
);
  import rv_pkg::*;

  xword_t regs [32];

  always_ff @(posedge clk_div) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= (i == 2) ? sp_reset : '0;  // x2 holds the stack pointer
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];  // x0 hardwired
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/rv_core_top.sv */
/* In-order RV64I core, fetch over Wishbone classic, results on the retire port.
   No branches, loads or stores; RAW hazards stall decode. */
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_pkg::xword_t pc_reset = 64'd0,
  parameter rv_pkg::xword_t sp_reset = 64'd128
) (
  input  logic             clk_div,
  input  logic             reset,
  output logic             wb_cyc,
  output logic             wb_stb,
  output rv_pkg::xword_t   wb_adr,
  input  logic             wb_ack,
  input  rv_pkg::instr_t   wb_dat_i,
  output logic             retire_valid,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::xword_t   retire_data
);
  import rv_pkg::*;

  logic     instr_valid;
  instr_t   instr;
  logic     instr_take;
  reg_idx_t rs1_addr;
  reg_idx_t rs2_addr;
  xword_t   rs1_data;
  xword_t   rs2_data;
  logic     ex_valid;
  alu_op_t  ex_op;
  xword_t   ex_a;
  xword_t   ex_b;
  reg_idx_t ex_rd;

  fetch_unit #(.pc_reset(pc_reset)) u_fetch (
    .clk_div, .reset,
    .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_i,
    .instr_take, .instr_valid, .instr
  );

  decode_stage u_decode (
    .clk_div, .reset,
    .instr_valid, .instr, .instr_take,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wb_valid (retire_valid),  // Write-back stage for the interlock
    .wb_rd    (retire_rd),
    .ex_valid, .ex_op, .ex_a, .ex_b, .ex_rd
  );

  register_file #(.sp_reset(sp_reset)) u_regs (
    .clk_div, .reset,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wr_en   (retire_valid),
    .wr_addr (retire_rd),
    .wr_data (retire_data)
  );

  execute_alu u_exec (
    .clk_div, .reset,
    .ex_valid, .ex_op, .ex_a, .ex_b, .ex_rd,
    .retire_valid, .retire_rd, .retire_data
  );

endmodule

/* hdl/rv_pkg.sv */
/* RV64I encodings and ALU actions for the integer core.
   Only the OP, OP-IMM and LUI major opcodes are decoded. */
package rv_pkg;

  localparam int xlen    = 64;
  localparam int shamt_w = 6;  // RV64 shift amount width

  typedef logic [xlen-1:0] xword_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcodes kept by the core
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB, SRA, SRAI

  localparam logic [2:0] f3_add  = 3'b000;  // ADD, SUB, ADDI
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;  // SRL and SRA share funct3
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // One action per ALU result
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // LUI result is the prepared immediate
  } alu_op_t;

endpackage

/* list.f */
hdl/rv_pkg.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_alu.sv
hdl/rv_core_top.sv
dv/clock_gen.sv
dv/tb_rv_core.sv
